// File: list.f
+incdir+.
ifu_pkg.sv
ifu_pc_gen.sv
ifu_fetch_ctrl.sv
ifu_top.sv
tb_imem.sv
tb_ifu.sv

// File: Makefile
SRCS := $(wildcard *.sv *.svh)

.PHONY: all run clean

all: run

obj_dir/Vtb_ifu: list.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_ifu -f list.f --Mdir obj_dir -o Vtb_ifu

run: obj_dir/Vtb_ifu
	@out="$$(./obj_dir/Vtb_ifu)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf obj_dir

// File: tb_ifu.sv
`timescale 1ns/1ps

`include "ifu_defs.svh"

module tb_ifu
    import ifu_pkg::*;
();

    localparam int FETCH_TIMEOUT = 200;

    logic                 clk;
    logic                 rst_n;
    redirect_t            redirect;
    trap_t                trap;
    logic                 hold;
    rd_req_t              rd_req;
    logic                 rd_req_ready;
    rd_rsp_t              rd_rsp;
    logic                 rd_rsp_ready;
    fetch_out_t           fetch;
    logic                 mem_err;
    logic [15:0]          lfsr;
    logic [`IFU_XLEN-1:0] next_pc;
    logic [`IFU_XLEN-1:0] last_pc;
    logic                 timed_out;
    int                   test_errors;
    int                   errors;
    int                   tests_run;
    int                   tests_failed;

    ifu_top uut (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .redirect_i     (redirect),
        .trap_i         (trap),
        .hold_i         (hold),
        .rd_req_o       (rd_req),
        .rd_req_ready_i (rd_req_ready),
        .rd_rsp_i       (rd_rsp),
        .rd_rsp_ready_o (rd_rsp_ready),
        .fetch_o        (fetch)
    );

    tb_imem u_imem (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .rd_req_i       (rd_req),
        .rd_req_ready_o (rd_req_ready),
        .rd_rsp_o       (rd_rsp),
        .rd_rsp_ready_i (rd_rsp_ready),
        .err_o          (mem_err)
    );

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    // 16 bit fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int v);
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[15]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // instruction word stored at an address
    function automatic logic [`IFU_ILEN-1:0] inst_at(input logic [`IFU_XLEN-1:0] a);
        return a[31:0] ^ 32'h0013_0000;
    endfunction

    task automatic check_fetch(input string name, input fetch_out_t exp, input fetch_out_t act);
        if (!timed_out && act !== exp) begin
            $display("FAIL %s: expected pc %h inst %h, actual valid %b pc %h inst %h",
                     name, exp.pc, exp.inst, act.valid, act.pc, act.inst);
            test_errors++;
        end
    endtask

    task automatic check_pc(input string name, input logic [`IFU_XLEN-1:0] exp,
                            input logic [`IFU_XLEN-1:0] act);
        if (!timed_out && act !== exp) begin
            $display("FAIL %s: expected pc %h, actual pc %h", name, exp, act);
            test_errors++;
        end
    endtask

    // always steps one cycle first so a delivery is never seen twice
    task automatic wait_fetch(output fetch_out_t f);
        int waited;
        waited = 0;
        f      = '0;
        if (!timed_out) begin
            do begin
                @(posedge clk);
                #1;
                waited++;
            end while (!fetch.valid && waited < FETCH_TIMEOUT);
            if (fetch.valid) begin
                f = fetch;
            end else begin
                timed_out = 1'b1;
                $display("no instruction delivered within %0d cycles", FETCH_TIMEOUT);
            end
        end
    endtask

    // returns as the response appears, so the next edge completes the data handshake
    task automatic wait_rsp_arrival();
        int waited;
        waited = 0;
        if (!timed_out) begin
            while (!(rd_rsp.valid && rd_rsp_ready) && waited < FETCH_TIMEOUT) begin
                @(rd_rsp.valid or posedge clk);
                waited++;
            end
            if (!(rd_rsp.valid && rd_rsp_ready)) begin
                timed_out = 1'b1;
                $display("no read response arrived within %0d cycles", FETCH_TIMEOUT);
            end
        end
    endtask

    // pc moves on unless hold was high when the data arrived
    task automatic expect_next(input string name);
        fetch_out_t exp;
        fetch_out_t got;
        wait_fetch(got);
        exp.valid = 1'b1;
        exp.pc    = next_pc;
        exp.inst  = inst_at(next_pc);
        check_fetch(name, exp, got);
        last_pc = next_pc;
        if (!hold) begin
            next_pc = next_pc + `IFU_PC_STEP;
        end
    endtask

    task automatic pulse_flow(input redirect_t r, input trap_t t);
        redirect = r;
        trap     = t;
        @(posedge clk);
        #1;
        redirect = '0;
        trap     = '0;
    endtask

    // kind 0 is jal, 1 branch, 2 jalr with an odd base, anything else a trap to arg
    task automatic change_flow(input int kind, input logic [`IFU_XLEN-1:0] arg,
                               input logic [`IFU_XLEN-1:0] alu);
        redirect_t            r;
        trap_t                t;
        logic [`IFU_XLEN-1:0] sum;
        r          = '0;
        t          = '0;
        r.pc       = last_pc;
        r.imm      = arg;
        r.alu_res  = alu;
        r.rs1_data = `IFU_RESET_PC + 64'h1001;
        t.mtvec    = arg;
        sum        = r.rs1_data + arg;
        case (kind)
            0: begin
                r.jal   = 1'b1;
                next_pc = last_pc + arg;
            end
            1: begin
                r.branch = 1'b1;
                if (alu == '0) begin
                    next_pc = last_pc + arg;
                end
            end
            2: begin
                r.jalr  = 1'b1;
                next_pc = sum & ~64'h1;
            end
            default: begin
                t.trap  = 1'b1;
                next_pc = arg;
            end
        endcase
        pulse_flow(r, t);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (timed_out) begin
            $display("%s: stopped, the DUT stopped delivering instructions", name);
            tests_failed++;
        end else if (test_errors != 0) begin
            $display("%s: %0d mismatches", name, test_errors);
            tests_failed++;
        end else begin
            $display("%s: ok", name);
        end
        errors      = errors + test_errors;
        test_errors = 0;
    endtask

    task automatic boot_sequence();
        int k;
        for (k = 0; k < 8; k++) begin
            expect_next("boot_sequence");
        end
        finish_test("boot_sequence");
    endtask

    task automatic jal_and_branch();
        expect_next("jal_and_branch");
        change_flow(0, 64'h100, '0);
        expect_next("jal_and_branch");
        // taken branch backwards by 64 bytes
        change_flow(1, 64'hFFFF_FFFF_FFFF_FFC0, '0);
        expect_next("jal_and_branch");
        change_flow(1, 64'h40, 64'h5);
        expect_next("jal_and_branch");
        expect_next("jal_and_branch");
        // jump landing on the edge that completes the data handshake
        wait_rsp_arrival();
        change_flow(0, 64'h200, '0);
        expect_next("jal_and_branch");
        finish_test("jal_and_branch");
    endtask

    task automatic jalr_odd_target();
        change_flow(2, 64'h24, '0);
        expect_next("jalr_odd_target");
        expect_next("jalr_odd_target");
        finish_test("jalr_odd_target");
    endtask

    task automatic trap_priority();
        redirect_t r;
        trap_t     t;
        change_flow(3, `IFU_RESET_PC + 64'h400, '0);
        expect_next("trap_priority");
        r          = '0;
        r.jal      = 1'b1;
        r.jalr     = 1'b1;
        r.pc       = last_pc;
        r.imm      = 64'h80;
        r.rs1_data = `IFU_RESET_PC + 64'h3000;
        t.trap     = 1'b1;
        t.mtvec    = `IFU_RESET_PC + 64'h800;
        pulse_flow(r, t);
        next_pc = last_pc + 64'h80;
        expect_next("trap_priority");
        expect_next("trap_priority");
        finish_test("trap_priority");
    endtask

    task automatic hold_refetch();
        fetch_out_t           got;
        logic [`IFU_XLEN-1:0] held_pc;
        held_pc = next_pc;
        hold    = 1'b1;
        wait_fetch(got);
        check_pc("hold_refetch", held_pc, got.pc);
        hold = 1'b0;
        wait_fetch(got);
        check_pc("hold_refetch", held_pc, got.pc);
        last_pc = held_pc;
        next_pc = held_pc + `IFU_PC_STEP;
        expect_next("hold_refetch");
        finish_test("hold_refetch");
    endtask

    task automatic random_flow();
        int n;
        int gap;
        int kind;
        int offs;
        for (n = 0; n < 40; n++) begin
            expect_next("random_flow");
            take_bits(2, gap);
            if (gap == 0) begin
                take_bits(2, kind);
                take_bits(6, offs);
                if (kind == 3) begin
                    change_flow(kind, `IFU_RESET_PC + 64'h200 + (64'(offs) << 2), '0);
                end else begin
                    change_flow(kind, 64'(offs) << 2, 64'(offs & 1));
                end
            end
        end
        finish_test("random_flow");
    endtask

    initial begin
        rst_n        = 1'b0;
        redirect     = '0;
        trap         = '0;
        hold         = 1'b0;
        lfsr         = 16'd42;
        next_pc      = `IFU_RESET_PC;
        last_pc      = `IFU_RESET_PC;
        timed_out    = 1'b0;
        test_errors  = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (2) begin
            @(posedge clk);
        end
        #1;
        rst_n = 1'b1;
        boot_sequence();
        jal_and_branch();
        jalr_odd_target();
        trap_priority();
        hold_refetch();
        random_flow();
        $display("tests %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0 && !timed_out && !mem_err) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: tb_imem.sv
`timescale 1ns/1ps

`include "ifu_defs.svh"

module tb_imem
    import ifu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  rd_req_t rd_req_i,
    output logic    rd_req_ready_o,
    output rd_rsp_t rd_rsp_o,
    input  logic    rd_rsp_ready_i,
    output logic    err_o
);

    localparam int WAIT_LIMIT = 64;

    logic [15:0] lfsr;
    int          idle;

    // 16 bit fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int v);
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[15]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic serve_request();
        logic [`IFU_XLEN-1:0] addr;
        int                   delay;
        int                   waited;
        logic                 taken;
        addr = rd_req_i.addr;
        // address accepted after 0 to 3 cycles
        take_bits(2, delay);
        repeat (delay) begin
            @(posedge clk);
            #1;
        end
        rd_req_ready_o = 1'b1;
        @(posedge clk);
        #1;
        rd_req_ready_o = 1'b0;
        // data 1 to 4 cycles after the address handshake
        take_bits(2, delay);
        repeat (delay) begin
            @(posedge clk);
            #1;
        end
        rd_rsp_o.valid = 1'b1;
        rd_rsp_o.data  = {32'h0, addr[31:0] ^ 32'h0013_0000};
        waited = 0;
        taken  = 1'b0;
        while (!taken && waited < WAIT_LIMIT) begin
            taken = rd_rsp_ready_i;
            @(posedge clk);
            #1;
            waited++;
        end
        rd_rsp_o = '0;
        if (!taken) begin
            $display("memory model: response not taken within %0d cycles", WAIT_LIMIT);
            err_o = 1'b1;
        end
    endtask

    initial begin
        lfsr           = 16'd42;
        rd_req_ready_o = 1'b0;
        rd_rsp_o       = '0;
        err_o          = 1'b0;
        idle           = 0;
        forever begin
            @(posedge clk);
            #1;
            if (rd_req_i.valid === 1'b1) begin
                idle = 0;
                serve_request();
            end else if (rst_n_i) begin
                idle++;
                if (idle == WAIT_LIMIT) begin
                    $display("memory model: no read request for %0d cycles", WAIT_LIMIT);
                    err_o = 1'b1;
                end
            end
        end
    end

endmodule

// File: ifu_top.sv
`timescale 1ns/1ps

`include "ifu_defs.svh"

module ifu_top
    import ifu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  redirect_t  redirect_i,
    input  trap_t      trap_i,
    input  logic       hold_i,
    output rd_req_t    rd_req_o,
    input  logic       rd_req_ready_i,
    input  rd_rsp_t    rd_rsp_i,
    output logic       rd_rsp_ready_o,
    output fetch_out_t fetch_o
);

    logic [`IFU_XLEN-1:0] pc;
    logic                 redirect_taken;
    logic                 fetch_done;

    // program counter and redirect priority
    ifu_pc_gen u_pc_gen (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .redirect_i       (redirect_i),
        .trap_i           (trap_i),
        .hold_i           (hold_i),
        .fetch_done_i     (fetch_done),
        .pc_o             (pc),
        .redirect_taken_o (redirect_taken)
    );

    // read channel sequencer where a redirect flushes the response in flight
    ifu_fetch_ctrl u_fetch_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .pc_i           (pc),
        .flush_i        (redirect_taken),
        .rd_req_o       (rd_req_o),
        .rd_req_ready_i (rd_req_ready_i),
        .rd_rsp_i       (rd_rsp_i),
        .rd_rsp_ready_o (rd_rsp_ready_o),
        .fetch_done_o   (fetch_done),
        .fetch_o        (fetch_o)
    );

endmodule

// File: ifu_fetch_ctrl.sv
`timescale 1ns/1ps

`include "ifu_defs.svh"

module ifu_fetch_ctrl
    import ifu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic [`IFU_XLEN-1:0] pc_i,
    input  logic                 flush_i,
    output rd_req_t              rd_req_o,
    input  logic                 rd_req_ready_i,
    input  rd_rsp_t              rd_rsp_i,
    output logic                 rd_rsp_ready_o,
    output logic                 fetch_done_o,
    output fetch_out_t           fetch_o
);

    typedef enum logic [1:0] {
        ST_ISSUE = 2'd0,
        ST_ADDR  = 2'd1,
        ST_DATA  = 2'd2
    } fetch_state_e;

    fetch_state_e         state_q;
    logic                 req_valid_q;
    logic [`IFU_XLEN-1:0] req_addr_q;
    logic                 rsp_ready_q;
    logic                 req_hs;
    logic                 rsp_hs;
    logic                 out_valid_q;
    logic [`IFU_XLEN-1:0] out_pc_q;
    logic [`IFU_ILEN-1:0] out_inst_q;

    assign req_hs = req_valid_q && rd_req_ready_i;
    assign rsp_hs = rd_rsp_i.valid && rsp_ready_q;

    // response is good only if it is for the live pc and no redirect lands now
    assign fetch_done_o = rsp_hs && (req_addr_q == pc_i) && !flush_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= ST_ISSUE;
            req_valid_q <= 1'b0;
            rsp_ready_q <= 1'b0;
        end else begin
            case (state_q)
                ST_ISSUE: begin
                    req_valid_q <= 1'b1;
                    state_q     <= ST_ADDR;
                end
                ST_ADDR: begin
                    // hold the request until memory takes it
                    if (req_hs) begin
                        req_valid_q <= 1'b0;
                        rsp_ready_q <= 1'b1;
                        state_q     <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    // stale responses are consumed here as well
                    if (rsp_hs) begin
                        rsp_ready_q <= 1'b0;
                        state_q     <= ST_ISSUE;
                    end
                end
                default: begin
                    req_valid_q <= 1'b0;
                    rsp_ready_q <= 1'b0;
                    state_q     <= ST_ISSUE;
                end
            endcase
        end
    end

    // request address, sampled from the pc as it stands at issue
    always_ff @(posedge clk) begin
        if (state_q == ST_ISSUE) begin
            req_addr_q <= pc_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= fetch_done_o;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_hs) begin
            out_pc_q   <= req_addr_q;
            out_inst_q <= rd_rsp_i.data[`IFU_ILEN-1:0];
        end
    end

    assign rd_req_o.valid = req_valid_q;
    assign rd_req_o.addr  = req_addr_q;
    assign rd_rsp_ready_o = rsp_ready_q;

    assign fetch_o.valid = out_valid_q;
    assign fetch_o.pc    = out_pc_q;
    assign fetch_o.inst  = out_inst_q;

    // back-pressure keeps the request unchanged
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (rd_req_o.valid && !rd_req_ready_i) |=> (rd_req_o.valid && $stable(rd_req_o.addr))
    ) else $error("read request changed under back-pressure");

    // one request in flight, so the two phases never overlap
    a_phase_excl: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(rd_req_o.valid && rd_rsp_ready_o)
    ) else $error("address and data phase active together");

endmodule

// File: ifu_pc_gen.sv
`timescale 1ns/1ps

`include "ifu_defs.svh"

module ifu_pc_gen
    import ifu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  redirect_t            redirect_i,
    input  trap_t                trap_i,
    input  logic                 hold_i,
    input  logic                 fetch_done_i,
    output logic [`IFU_XLEN-1:0] pc_o,
    output logic                 redirect_taken_o
);

    logic [`IFU_XLEN-1:0] pc_q;
    logic [`IFU_XLEN-1:0] pc_d;
    logic [`IFU_XLEN-1:0] jal_target;
    logic [`IFU_XLEN-1:0] jalr_sum;
    logic [`IFU_XLEN-1:0] jalr_target;
    logic                 br_taken;

    // jal always jumps, a branch only when the compare result is zero
    assign br_taken = redirect_i.jal ||
                      (redirect_i.branch && (redirect_i.alu_res == '0));

    assign jal_target  = redirect_i.pc + redirect_i.imm;
    assign jalr_sum    = redirect_i.rs1_data + redirect_i.imm;
    // jalr target with bit 0 forced low
    assign jalr_target = {jalr_sum[`IFU_XLEN-1:1], 1'b0};

    // any change of flow makes the response in flight stale
    assign redirect_taken_o = br_taken || redirect_i.jalr || trap_i.trap;

    // next pc with the highest priority first
    always_comb begin
        pc_d = pc_q;
        if (br_taken) begin
            pc_d = jal_target;
        end else if (redirect_i.jalr) begin
            pc_d = jalr_target;
        end else if (trap_i.trap) begin
            pc_d = trap_i.mtvec;
        end else if (fetch_done_i && !hold_i) begin
            pc_d = pc_q + `IFU_PC_STEP;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= `IFU_RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

    // an odd pc from any redirect source is a bug upstream
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !pc_q[0]
    ) else $error("pc bit 0 set: %h", pc_q);

endmodule

// File: ifu_pkg.sv
`include "ifu_defs.svh"

package ifu_pkg;

    // control transfer request from the memory stage
    typedef struct packed {
        logic                 jal;
        logic                 jalr;
        logic                 branch;
        logic [`IFU_XLEN-1:0] alu_res;
        logic [`IFU_XLEN-1:0] pc;
        logic [`IFU_XLEN-1:0] imm;
        logic [`IFU_XLEN-1:0] rs1_data;
    } redirect_t;

    // trap request from the CSR unit
    typedef struct packed {
        logic                 trap;
        logic [`IFU_XLEN-1:0] mtvec;
    } trap_t;

    // instruction handed to decode
    typedef struct packed {
        logic                 valid;
        logic [`IFU_XLEN-1:0] pc;
        logic [`IFU_ILEN-1:0] inst;
    } fetch_out_t;

    // read channel address phase
    typedef struct packed {
        logic                 valid;
        logic [`IFU_XLEN-1:0] addr;
    } rd_req_t;

    // read channel data phase
    typedef struct packed {
        logic                 valid;
        logic [`IFU_XLEN-1:0] data;
    } rd_rsp_t;

endpackage

// File: ifu_defs.svh
`ifndef IFU_DEFS_SVH
`define IFU_DEFS_SVH

// boot address of the core
`define IFU_RESET_PC 64'h0000_0000_8000_0000

// address and data width
`define IFU_XLEN 64

// instruction width without compressed support
`define IFU_ILEN 32

// sequential pc increment
`define IFU_PC_STEP 64'd4

`endif
